// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= wmem_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/wmem_properties.sv ====
`timescale 1ns/100ps

module wmem_properties (
    input logic S_AXI_ACLK,
    input logic S_AXI_ARESETn,
    // write side
    input logic bvalid,
    input logic bready,
    input logic wen,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    // pl read side
    input logic rclk,
    input logic ren,
    input logic rvalid
);

    // beats taken by a handshake and not yet written to the ram
    logic aw_held;
    logic w_held;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            aw_held <= 1'b0;
        end else begin
            aw_held <= (aw_held || (awvalid && awready)) && !wen;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            w_held <= 1'b0;
        end else begin
            w_held <= (w_held || (wvalid && wready)) && !wen;
        end
    end

    // response stays up until the master takes it
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETn)
        bvalid && !bready |=> bvalid)
        else $error("BVALID dropped while BREADY was low");

    // ram write only with an address and a data beat taken on the bus
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETn)
        wen |-> (aw_held || (awvalid && awready)) && (w_held || (wvalid && wready)))
        else $error("wen raised without both address and data");

    // exactly one rclk of read latency
    assert property (@(posedge rclk) disable iff (!S_AXI_ARESETn)
        ren |=> rvalid)
        else $error("rvalid missing one rclk after ren");

    assert property (@(posedge rclk) disable iff (!S_AXI_ARESETn)
        !ren |=> !rvalid)
        else $error("rvalid without ren on the previous rclk");

endmodule

// write slave checks, do_write drives wen
bind axil_write_slave wmem_properties u_write_props (
    .S_AXI_ACLK     (S_AXI_ACLK),
    .S_AXI_ARESETn  (S_AXI_ARESETn),
    .bvalid         (S_AXI_BVALID),
    .bready         (S_AXI_BREADY),
    .wen            (do_write),
    .awvalid        (S_AXI_AWVALID),
    .awready        (S_AXI_AWREADY),
    .wvalid         (S_AXI_WVALID),
    .wready         (S_AXI_WREADY),
    .rclk           (1'b0),
    .ren            (1'b0),
    .rvalid         (1'b0)
);

// ram read port, write side tied off
bind bram_async wmem_properties u_read_props (
    .S_AXI_ACLK     (S_AXI_ACLK),
    .S_AXI_ARESETn  (S_AXI_ARESETn),
    .bvalid         (1'b0),
    .bready         (1'b0),
    .wen            (1'b0),
    .awvalid        (1'b0),
    .awready        (1'b0),
    .wvalid         (1'b0),
    .wready         (1'b0),
    .rclk           (rclk),
    .ren            (ren),
    .rvalid         (rvalid)
);

// ==== dv/wmem_tb.sv ====
`timescale 1ns/100ps

module wmem_tb;

    localparam int ACLK_PERIOD = 40;
    localparam int RCLK_PERIOD = 28;
    localparam int NUM_ENTRIES = 21;
    localparam logic [31:0] LCG_SEED = 32'd43456;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_PLREAD,
        OP_AXIREAD
    } op_e;

    // one table row
    // skew above zero delays the data beat, below zero the address beat
    typedef struct packed {
        op_e                            op;
        logic [wmem_pkg::ADDR_W-1:0]    addr;
        logic [wmem_pkg::DATA_W-1:0]    data;
        logic [wmem_pkg::STRB_W-1:0]    strb;
        logic signed [7:0]              skew;
        wmem_pkg::axi_resp_e            resp;
    } entry_t;

    logic                           S_AXI_ACLK;
    logic                           S_AXI_ARESETn;
    logic [wmem_pkg::ADDR_W-1:0]    S_AXI_AWADDR;
    logic [2:0]                     S_AXI_AWPROT;
    logic                           S_AXI_AWVALID;
    logic                           S_AXI_AWREADY;
    logic [wmem_pkg::DATA_W-1:0]    S_AXI_WDATA;
    logic [wmem_pkg::STRB_W-1:0]    S_AXI_WSTRB;
    logic                           S_AXI_WVALID;
    logic                           S_AXI_WREADY;
    logic [1:0]                     S_AXI_BRESP;
    logic                           S_AXI_BVALID;
    logic                           S_AXI_BREADY;
    logic [wmem_pkg::ADDR_W-1:0]    S_AXI_ARADDR;
    logic [2:0]                     S_AXI_ARPROT;
    logic                           S_AXI_ARVALID;
    logic                           S_AXI_ARREADY;
    logic [wmem_pkg::DATA_W-1:0]    S_AXI_RDATA;
    logic [1:0]                     S_AXI_RRESP;
    logic                           S_AXI_RVALID;
    logic                           S_AXI_RREADY;
    logic                           rclk;
    logic                           ren;
    logic [wmem_pkg::WORD_AW-1:0]   raddr;
    logic [wmem_pkg::DATA_W-1:0]    rout;
    logic                           rvalid;

    entry_t stim [NUM_ENTRIES] = '{
        // full word, then readback
        '{OP_WRITE,   8'h00, 32'h1122_3344, 4'hF,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_PLREAD,  8'h00, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_OKAY},
        // partial strobes merged into one word
        '{OP_WRITE,   8'h04, 32'hA5A5_A5A5, 4'hF,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_WRITE,   8'h05, 32'h0000_BE00, 4'h2,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_WRITE,   8'h04, 32'h7F00_0000, 4'h8,  8'sd3, wmem_pkg::RESP_OKAY},
        '{OP_PLREAD,  8'h04, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_OKAY},
        // address and data apart, both orders
        '{OP_WRITE,   8'h10, 32'hCAFE_F00D, 4'hF, -8'sd4, wmem_pkg::RESP_OKAY},
        '{OP_WRITE,   8'h14, 32'h0102_0304, 4'hF,  8'sd2, wmem_pkg::RESP_OKAY},
        '{OP_WRITE,   8'h18, 32'h5555_AAAA, 4'hF, -8'sd1, wmem_pkg::RESP_OKAY},
        // back to back under bready stalls
        '{OP_WRITE,   8'h20, 32'h2020_2020, 4'hF,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_WRITE,   8'h24, 32'h2424_2424, 4'hF,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_WRITE,   8'h28, 32'h2828_2828, 4'hF,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_WRITE,   8'h20, 32'h0000_00EE, 4'h1,  8'sd0, wmem_pkg::RESP_OKAY},
        // processor reads, always refused
        '{OP_AXIREAD, 8'h08, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_SLVERR},
        '{OP_AXIREAD, 8'h3C, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_SLVERR},
        // pl burst
        '{OP_PLREAD,  8'h10, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_PLREAD,  8'h14, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_PLREAD,  8'h18, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_PLREAD,  8'h20, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_PLREAD,  8'h24, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_OKAY},
        '{OP_PLREAD,  8'h28, 32'h0000_0000, 4'h0,  8'sd0, wmem_pkg::RESP_OKAY}
    };

    // model of the ram contents and the responses still owed
    logic [wmem_pkg::DATA_W-1:0]    ref_mem [wmem_pkg::DEPTH];
    wmem_pkg::axi_resp_e            b_exp [$];
    logic [wmem_pkg::DATA_W-1:0]    pl_exp [$];
    logic [31:0]                    lcg_state = LCG_SEED;

    wmem_top UUT (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #(ACLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
    end

    initial begin
        rclk = 1'b0;
        forever #(RCLK_PERIOD / 2) rclk = ~rclk;
    end

    task automatic end_with_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_resp(input string name, input wmem_pkg::axi_resp_e got,
                              input wmem_pkg::axi_resp_e exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [wmem_pkg::DATA_W-1:0] got,
                              input logic [wmem_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    // lcg, about half the draws stall
    function automatic logic random_ready();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[22];
    endfunction

    // bready and rready drawn once per cycle
    initial begin
        S_AXI_BREADY = 1'b0;
        S_AXI_RREADY = 1'b0;
        wait (S_AXI_ARESETn === 1'b1);
        forever begin
            @(posedge S_AXI_ACLK);
            #2;
            S_AXI_BREADY = random_ready();
            S_AXI_RREADY = random_ready();
        end
    end

    // write responses, one per issued write, in order
    always @(negedge S_AXI_ACLK) begin
        if (S_AXI_ARESETn && S_AXI_BVALID && S_AXI_BREADY) begin
            if (b_exp.size() == 0) begin
                $display("write response seen with no write outstanding");
                end_with_failure();
            end else begin
                check_resp("S_AXI_BRESP", wmem_pkg::axi_resp_e'(S_AXI_BRESP), b_exp.pop_front());
            end
        end
    end

    // pl read data, one rvalid per ren, in issue order
    always @(negedge rclk) begin
        if (rvalid === 1'b1) begin
            if (pl_exp.size() == 0) begin
                $display("rvalid seen with no pl read in flight");
                end_with_failure();
            end else begin
                check_word("rout", rout, pl_exp.pop_front());
            end
        end
    end

    // merge into the model, then offer both beats with the row's skew
    task automatic axi_write(input entry_t e);
        int aw_wait;
        int w_wait;
        int lane;
        logic aw_taken;
        logic w_taken;
        logic [wmem_pkg::WORD_AW-1:0] word;
        word = e.addr[wmem_pkg::ADDR_W-1:wmem_pkg::ADDR_LSB];
        aw_wait = ($signed(e.skew) < 0) ? -$signed(e.skew) : 0;
        w_wait = ($signed(e.skew) > 0) ? $signed(e.skew) : 0;
        for (lane = 0; lane < wmem_pkg::STRB_W; lane++) begin
            if (e.strb[lane]) begin
                ref_mem[word][8*lane +: 8] = e.data[8*lane +: 8];
            end
        end
        b_exp.push_back(e.resp);
        fork
            begin
                repeat (aw_wait) begin
                    @(posedge S_AXI_ACLK);
                    #2;
                end
                S_AXI_AWADDR = e.addr;
                S_AXI_AWVALID = 1'b1;
                aw_taken = 1'b0;
                while (!aw_taken) begin
                    aw_taken = S_AXI_AWREADY;
                    @(posedge S_AXI_ACLK);
                    #2;
                end
                S_AXI_AWVALID = 1'b0;
            end
            begin
                repeat (w_wait) begin
                    @(posedge S_AXI_ACLK);
                    #2;
                end
                S_AXI_WDATA = e.data;
                S_AXI_WSTRB = e.strb;
                S_AXI_WVALID = 1'b1;
                w_taken = 1'b0;
                while (!w_taken) begin
                    w_taken = S_AXI_WREADY;
                    @(posedge S_AXI_ACLK);
                    #2;
                end
                S_AXI_WVALID = 1'b0;
            end
        join
    endtask

    task automatic axi_read(input entry_t e);
        logic taken;
        logic seen;
        logic done;
        S_AXI_ARADDR = e.addr;
        S_AXI_ARVALID = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            taken = S_AXI_ARREADY;
            @(posedge S_AXI_ACLK);
            #2;
        end
        S_AXI_ARVALID = 1'b0;
        // rvalid must stay up through every rready stall
        seen = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge S_AXI_ACLK);
            if (S_AXI_RVALID) begin
                seen = 1'b1;
                done = S_AXI_RREADY;
            end else if (seen) begin
                $display("RVALID dropped before RREADY took the read response");
                end_with_failure();
            end
        end
        check_resp("S_AXI_RRESP", wmem_pkg::axi_resp_e'(S_AXI_RRESP), e.resp);
        check_word("S_AXI_RDATA", S_AXI_RDATA, e.data);
        @(posedge S_AXI_ACLK);
        #2;
    endtask

    // every response back, then two rclk edges of margin
    task automatic settle_writes();
        while (b_exp.size() != 0) begin
            @(posedge S_AXI_ACLK);
            #2;
        end
        repeat (2) @(posedge rclk);
    endtask

    task automatic pl_read(input entry_t e);
        @(posedge rclk);
        #2;
        ren = 1'b1;
        raddr = e.addr[wmem_pkg::ADDR_W-1:wmem_pkg::ADDR_LSB];
        pl_exp.push_back(ref_mem[raddr]);
    endtask

    // watchdog, 40 cycles per table row plus reset
    initial begin
        #((NUM_ENTRIES * 40 + 8) * ACLK_PERIOD);
        $display("timeout, the stimulus table did not finish in time");
        end_with_failure();
    end

    initial begin
        int i;
        logic prev_pl;
        logic next_pl;
        S_AXI_ARESETn = 1'b0;
        S_AXI_AWADDR = '0;
        S_AXI_AWPROT = 3'b000;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA = '0;
        S_AXI_WSTRB = '0;
        S_AXI_WVALID = 1'b0;
        S_AXI_ARADDR = '0;
        S_AXI_ARPROT = 3'b000;
        S_AXI_ARVALID = 1'b0;
        ren = 1'b0;
        raddr = '0;
        repeat (8) @(posedge S_AXI_ACLK);
        #2;
        S_AXI_ARESETn = 1'b1;
        check_bit("S_AXI_AWREADY", S_AXI_AWREADY, 1'b1);
        check_bit("S_AXI_WREADY", S_AXI_WREADY, 1'b1);
        check_bit("S_AXI_ARREADY", S_AXI_ARREADY, 1'b1);
        check_bit("S_AXI_BVALID", S_AXI_BVALID, 1'b0);
        check_bit("S_AXI_RVALID", S_AXI_RVALID, 1'b0);
        check_bit("rvalid", rvalid, 1'b0);
        prev_pl = 1'b0;
        for (i = 0; i < NUM_ENTRIES; i++) begin
            next_pl = 1'b0;
            if (i < NUM_ENTRIES - 1) begin
                next_pl = (stim[i+1].op == OP_PLREAD);
            end
            case (stim[i].op)
                OP_WRITE: axi_write(stim[i]);
                OP_AXIREAD: axi_read(stim[i]);
                default: begin
                    // consecutive pl rows go out on consecutive rclk edges
                    if (!prev_pl) begin
                        settle_writes();
                    end
                    pl_read(stim[i]);
                    if (!next_pl) begin
                        @(posedge rclk);
                        #2;
                        ren = 1'b0;
                        @(posedge S_AXI_ACLK);
                        #2;
                    end
                end
            endcase
            prev_pl = (stim[i].op == OP_PLREAD);
        end
        settle_writes();
        while (pl_exp.size() != 0) begin
            @(posedge rclk);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/wmem_pkg.sv
verilog/mem_wr_if.sv
verilog/axil_write_slave.sv
verilog/bram_async.sv
verilog/axil_read_reject.sv
verilog/wmem_top.sv
dv/wmem_properties.sv
dv/wmem_tb.sv

// ==== verilog/axil_read_reject.sv ====
`timescale 1ns/100ps

module axil_read_reject (
    input  logic                            S_AXI_ACLK,
    input  logic                            S_AXI_ARESETn,
    // read address channel, address is never decoded
    input  logic [wmem_pkg::ADDR_W-1:0]     S_AXI_ARADDR,
    input  logic                            S_AXI_ARVALID,
    output logic                            S_AXI_ARREADY,
    // read data channel
    output logic [wmem_pkg::DATA_W-1:0]     S_AXI_RDATA,
    output wmem_pkg::axi_resp_e             S_AXI_RRESP,
    output logic                            S_AXI_RVALID,
    input  logic                            S_AXI_RREADY
);

    wmem_pkg::rd_state_e state_q;

    // idle takes one address, resp waits for rready
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            state_q <= wmem_pkg::RD_IDLE;
        end else begin
            case (state_q)
                wmem_pkg::RD_IDLE: begin
                    if (S_AXI_ARVALID) begin
                        state_q <= wmem_pkg::RD_RESP;
                    end
                end
                wmem_pkg::RD_RESP: begin
                    if (S_AXI_RREADY) begin
                        state_q <= wmem_pkg::RD_IDLE;
                    end
                end
                default: state_q <= wmem_pkg::RD_IDLE;
            endcase
        end
    end

    assign S_AXI_ARREADY = (state_q == wmem_pkg::RD_IDLE);
    assign S_AXI_RVALID  = (state_q == wmem_pkg::RD_RESP);

    // memory is write only from the processor side, every read refused
    assign S_AXI_RDATA   = '0;
    assign S_AXI_RRESP   = wmem_pkg::RESP_SLVERR;

endmodule

// ==== verilog/axil_write_slave.sv ====
`timescale 1ns/100ps

module axil_write_slave (
    input  logic                            S_AXI_ACLK,
    input  logic                            S_AXI_ARESETn,
    // write address channel
    input  logic [wmem_pkg::ADDR_W-1:0]     S_AXI_AWADDR,
    input  logic                            S_AXI_AWVALID,
    output logic                            S_AXI_AWREADY,
    // write data channel
    input  logic [wmem_pkg::DATA_W-1:0]     S_AXI_WDATA,
    input  logic [wmem_pkg::STRB_W-1:0]     S_AXI_WSTRB,
    input  logic                            S_AXI_WVALID,
    output logic                            S_AXI_WREADY,
    // write response channel
    output wmem_pkg::axi_resp_e             S_AXI_BRESP,
    output logic                            S_AXI_BVALID,
    input  logic                            S_AXI_BREADY,
    // ram write port
    mem_wr_if.source                        mem
);

    // ready registers, low means the skid register holds a beat
    logic                           awready_q;
    logic                           wready_q;
    logic                           bvalid_q;

    // skid registers
    logic [wmem_pkg::ADDR_W-1:0]    skid_addr_q;
    logic [wmem_pkg::DATA_W-1:0]    skid_data_q;
    logic [wmem_pkg::STRB_W-1:0]    skid_strb_q;

    // selected beat, live or parked
    logic [wmem_pkg::ADDR_W-1:0]    sel_addr;
    logic [wmem_pkg::DATA_W-1:0]    sel_data;
    logic [wmem_pkg::STRB_W-1:0]    sel_strb;

    // status flags
    logic                           addr_avail;
    logic                           data_avail;
    logic                           resp_stall;
    logic                           do_write;

    // a beat is available when offered now or parked earlier
    assign addr_avail = S_AXI_AWVALID || !awready_q;
    assign data_avail = S_AXI_WVALID || !wready_q;

    // response still waiting for the master
    assign resp_stall = bvalid_q && !S_AXI_BREADY;

    // write fires when both halves are here and the response slot is free
    assign do_write = addr_avail && data_avail && !resp_stall;

    // park the live beat while the channel is still open
    always_ff @(posedge S_AXI_ACLK) begin
        if (awready_q) begin
            skid_addr_q <= S_AXI_AWADDR;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (wready_q) begin
            skid_data_q <= S_AXI_WDATA;
            skid_strb_q <= S_AXI_WSTRB;
        end
    end

    // ready low selects the parked copy
    always_comb begin
        if (awready_q) begin
            sel_addr = S_AXI_AWADDR;
        end else begin
            sel_addr = skid_addr_q;
        end
    end

    always_comb begin
        if (wready_q) begin
            sel_data = S_AXI_WDATA;
            sel_strb = S_AXI_WSTRB;
        end else begin
            sel_data = skid_data_q;
            sel_strb = skid_strb_q;
        end
    end

    // address ready
    // reopens after a write, closes while a beat waits for its partner
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            awready_q <= 1'b1;
        end else begin
            awready_q <= do_write || !addr_avail;
        end
    end

    // data ready, same rule as the address side
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            wready_q <= 1'b1;
        end else begin
            wready_q <= do_write || !data_avail;
        end
    end

    // response valid
    // set one cycle after the ram write, cleared on bready
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            bvalid_q <= 1'b0;
        end else if (do_write) begin
            bvalid_q <= 1'b1;
        end else if (S_AXI_BREADY) begin
            bvalid_q <= 1'b0;
        end
    end

    assign S_AXI_AWREADY = awready_q;
    assign S_AXI_WREADY  = wready_q;
    assign S_AXI_BVALID  = bvalid_q;

    // every address lands in the ram, so always okay
    assign S_AXI_BRESP   = wmem_pkg::RESP_OKAY;

    // ram write port, byte offset dropped
    assign mem.wen   = do_write;
    assign mem.waddr = sel_addr[wmem_pkg::ADDR_W-1:wmem_pkg::ADDR_LSB];
    assign mem.wdata = sel_data;
    assign mem.wstrb = sel_strb;

endmodule

// ==== verilog/bram_async.sv ====
`timescale 1ns/100ps

module bram_async (
    // write clock domain
    input  logic                            S_AXI_ACLK,
    input  logic                            S_AXI_ARESETn,
    // pl read port
    input  logic                            rclk,
    input  logic                            ren,
    input  logic [wmem_pkg::WORD_AW-1:0]    raddr,
    output logic [wmem_pkg::DATA_W-1:0]     rout,
    output logic                            rvalid,
    // write port from the axi side
    mem_wr_if.ram                           mem
);

    // word storage
    logic [wmem_pkg::DATA_W-1:0]    ram_q [wmem_pkg::DEPTH];

    // reset seen in the rclk domain
    logic                           rst_n_r;

    // read output registers
    logic [wmem_pkg::DATA_W-1:0]    rout_q;
    logic                           rvalid_q;

    // byte lane writes on the axi clock
    // lanes with a clear strobe keep their old value
    always_ff @(posedge S_AXI_ACLK) begin
        if (mem.wen) begin
            for (int lane = 0; lane < wmem_pkg::STRB_W; lane++) begin
                if (mem.wstrb[lane]) begin
                    ram_q[mem.waddr][8*lane +: 8] <= mem.wdata[8*lane +: 8];
                end
            end
        end
    end

    // single register, reset only clears rvalid
    always_ff @(posedge rclk) begin
        rst_n_r <= S_AXI_ARESETn;
    end

    // registered read, one rclk of latency
    always_ff @(posedge rclk) begin
        if (ren) begin
            rout_q <= ram_q[raddr];
        end
    end

    // one rvalid pulse per ren, back to back allowed
    always_ff @(posedge rclk) begin
        if (!rst_n_r) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= ren;
        end
    end

    assign rout   = rout_q;
    assign rvalid = rvalid_q;

endmodule

// ==== verilog/mem_wr_if.sv ====
`timescale 1ns/100ps

interface mem_wr_if;

    // one word written on every S_AXI_ACLK edge with wen high
    logic                           wen;

    // word address, byte offset already removed
    logic [wmem_pkg::WORD_AW-1:0]   waddr;

    // write word and its byte lane enables
    logic [wmem_pkg::DATA_W-1:0]    wdata;
    logic [wmem_pkg::STRB_W-1:0]    wstrb;

    // axi side, produces the writes
    modport source (
        output wen,
        output waddr,
        output wdata,
        output wstrb
    );

    // ram side, always ready, so no signal goes back
    modport ram (
        input wen,
        input waddr,
        input wdata,
        input wstrb
    );

endinterface

// ==== verilog/wmem_pkg.sv ====
package wmem_pkg;

    // axi data bus width
    localparam int DATA_W = 32;

    // axi byte address width
    localparam int ADDR_W = 8;

    // byte offset inside one word, dropped to get the word address
    localparam int ADDR_LSB = 2;

    // word address width seen by the ram
    localparam int WORD_AW = ADDR_W - ADDR_LSB;

    // number of words in the ram
    localparam int DEPTH = 2 ** WORD_AW;

    // one strobe bit per byte lane
    localparam int STRB_W = DATA_W / 8;

    // axi response codes, bresp and rresp
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_EXOKAY = 2'd1,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axi_resp_e;

    // read responder states
    // idle takes an address, resp holds rvalid until rready
    typedef enum logic {
        RD_IDLE,
        RD_RESP
    } rd_state_e;

endpackage

// ==== verilog/wmem_top.sv ====
`timescale 1ns/100ps

module wmem_top (
    input  logic                            S_AXI_ACLK,
    input  logic                            S_AXI_ARESETn,
    // write address channel
    input  logic [wmem_pkg::ADDR_W-1:0]     S_AXI_AWADDR,
    input  logic [2:0]                      S_AXI_AWPROT,
    input  logic                            S_AXI_AWVALID,
    output logic                            S_AXI_AWREADY,
    // write data channel
    input  logic [wmem_pkg::DATA_W-1:0]     S_AXI_WDATA,
    input  logic [wmem_pkg::STRB_W-1:0]     S_AXI_WSTRB,
    input  logic                            S_AXI_WVALID,
    output logic                            S_AXI_WREADY,
    // write response channel
    output logic [1:0]                      S_AXI_BRESP,
    output logic                            S_AXI_BVALID,
    input  logic                            S_AXI_BREADY,
    // read address channel
    input  logic [wmem_pkg::ADDR_W-1:0]     S_AXI_ARADDR,
    input  logic [2:0]                      S_AXI_ARPROT,
    input  logic                            S_AXI_ARVALID,
    output logic                            S_AXI_ARREADY,
    // read data channel
    output logic [wmem_pkg::DATA_W-1:0]     S_AXI_RDATA,
    output logic [1:0]                      S_AXI_RRESP,
    output logic                            S_AXI_RVALID,
    input  logic                            S_AXI_RREADY,
    // pl read port
    input  logic                            rclk,
    input  logic                            ren,
    input  logic [wmem_pkg::WORD_AW-1:0]    raddr,
    output logic [wmem_pkg::DATA_W-1:0]     rout,
    output logic                            rvalid
);

    // protection inputs are accepted and not checked
    // ram write port between the axi slave and the ram
    mem_wr_if wr_port ();

    // axi write channels, skid buffered
    axil_write_slave u_write_slave (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .S_AXI_ARESETn  (S_AXI_ARESETn),
        .S_AXI_AWADDR   (S_AXI_AWADDR),
        .S_AXI_AWVALID  (S_AXI_AWVALID),
        .S_AXI_AWREADY  (S_AXI_AWREADY),
        .S_AXI_WDATA    (S_AXI_WDATA),
        .S_AXI_WSTRB    (S_AXI_WSTRB),
        .S_AXI_WVALID   (S_AXI_WVALID),
        .S_AXI_WREADY   (S_AXI_WREADY),
        .S_AXI_BRESP    (S_AXI_BRESP),
        .S_AXI_BVALID   (S_AXI_BVALID),
        .S_AXI_BREADY   (S_AXI_BREADY),
        .mem            (wr_port.source)
    );

    // dual clock word ram
    bram_async u_bram (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .S_AXI_ARESETn  (S_AXI_ARESETn),
        .rclk           (rclk),
        .ren            (ren),
        .raddr          (raddr),
        .rout           (rout),
        .rvalid         (rvalid),
        .mem            (wr_port.ram)
    );

    // axi read channel, slverr for every request
    axil_read_reject u_read_reject (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .S_AXI_ARESETn  (S_AXI_ARESETn),
        .S_AXI_ARADDR   (S_AXI_ARADDR),
        .S_AXI_ARVALID  (S_AXI_ARVALID),
        .S_AXI_ARREADY  (S_AXI_ARREADY),
        .S_AXI_RDATA    (S_AXI_RDATA),
        .S_AXI_RRESP    (S_AXI_RRESP),
        .S_AXI_RVALID   (S_AXI_RVALID),
        .S_AXI_RREADY   (S_AXI_RREADY)
    );

endmodule
